// File: rtl/cluster_intc_pkg.sv
/*
 * cluster interconnect package
 * shared widths, request payloads for the TCDM banks and the
 * peripheral slaves, and the cluster peripheral window constants
 */

`default_nettype none

package cluster_intc_pkg;

  parameter int unsigned DATA_WIDTH      = 32;
  parameter int unsigned ADDR_WIDTH      = 32;
  parameter int unsigned BE_WIDTH        = DATA_WIDTH / 8;
  // 256 words per bank
  parameter int unsigned BANK_ADDR_WIDTH = 8;

  // peripheral window, one 1 KiB slot per slave
  parameter logic [ADDR_WIDTH-1:0] CLUSTER_PERIPH_BASE = 32'h1020_0000;
  parameter int unsigned           PE_ROUTING_LSB      = 10;

  // wen follows the usual bus encoding: 1 reads, 0 writes
  typedef struct packed {
    logic                       wen;
    logic [BANK_ADDR_WIDTH-1:0] add;
    logic [DATA_WIDTH-1:0]      wdata;
    logic [BE_WIDTH-1:0]        be;
  } tcdm_req_t;

  typedef struct packed {
    logic                  wen;
    logic [ADDR_WIDTH-1:0] add;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0]   be;
  } periph_req_t;

endpackage

`default_nettype wire

// File: rtl/rr_arbiter.sv
/*
 * round-robin arbiter
 * picks one of N requesters starting at a rotating priority pointer,
 * forwards the winner payload and passes the downstream grant back
 */

`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
  parameter int unsigned N         = 4,
  parameter type         payload_t = logic,
  localparam int unsigned IDX_W    = (N > 1) ? $clog2(N) : 1
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic [N-1:0]     req_i,
  input  payload_t         data_i [N],
  output logic [N-1:0]     gnt_o,
  output logic             req_o,
  output payload_t         data_o,
  input  logic             gnt_i,
  output logic [IDX_W-1:0] idx_o
);

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] win;
  logic             found;

  // first requester at or after the pointer
  always_comb begin : pick
    int unsigned pos;
    found = 1'b0;
    win   = '0;
    for (int unsigned k = 0; k < N; k++) begin
      pos = (int'(ptr_q) + k) % N;
      if (!found && req_i[pos]) begin
        found = 1'b1;
        win   = IDX_W'(pos);
      end
    end
  end

  assign req_o  = found;
  assign data_o = data_i[win];
  assign idx_o  = win;

  always_comb begin
    gnt_o = '0;
    if (found && gnt_i) begin
      gnt_o[win] = 1'b1;
    end
  end

  // move priority just past the winner after an accepted transfer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (found && gnt_i) begin
      ptr_q <= (win == IDX_W'(N - 1)) ? '0 : win + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/tcdm_bank_sram.sv
/*
 * TCDM bank
 * single-port word SRAM with byte-enabled writes and
 * one cycle read latency
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_bank_sram (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       req_i,
  input  logic                                       wen_i,
  input  logic [cluster_intc_pkg::BANK_ADDR_WIDTH-1:0] add_i,
  input  logic [cluster_intc_pkg::DATA_WIDTH-1:0]      wdata_i,
  input  logic [cluster_intc_pkg::BE_WIDTH-1:0]        be_i,
  output logic [cluster_intc_pkg::DATA_WIDTH-1:0]      rdata_o
);

  import cluster_intc_pkg::*;

  logic [DATA_WIDTH-1:0] mem [2**BANK_ADDR_WIDTH];

  always_ff @(posedge clk_i) begin
    if (req_i && !wen_i) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (be_i[b]) mem[add_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // read port, holds its value across writes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_o <= '0;
    end else if (req_i && wen_i) begin
      rdata_o <= mem[add_i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/tcdm_log_intc.sv
/*
 * logarithmic interconnect to the TCDM
 * word-interleaved bank decode, one round-robin arbiter per bank,
 * responses steered back one cycle after the grant
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_log_intc #(
  parameter int unsigned NB_CORES      = 4,
  parameter int unsigned NB_TCDM_BANKS = 8,
  localparam int unsigned CORE_W       = (NB_CORES > 1) ? $clog2(NB_CORES) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [NB_CORES-1:0]                   core_tcdm_req_i,
  input  logic [cluster_intc_pkg::ADDR_WIDTH-1:0] core_tcdm_add_i [NB_CORES],
  input  logic [NB_CORES-1:0]                   core_tcdm_wen_i,
  input  logic [cluster_intc_pkg::DATA_WIDTH-1:0] core_tcdm_wdata_i [NB_CORES],
  input  logic [cluster_intc_pkg::BE_WIDTH-1:0]   core_tcdm_be_i [NB_CORES],
  output logic [NB_CORES-1:0]                   core_tcdm_gnt_o,
  output logic [NB_CORES-1:0]                   core_tcdm_r_valid_o,
  output logic [cluster_intc_pkg::DATA_WIDTH-1:0] core_tcdm_r_rdata_o [NB_CORES],
  output logic [NB_TCDM_BANKS-1:0]              bank_req_o,
  output cluster_intc_pkg::tcdm_req_t           bank_data_o [NB_TCDM_BANKS],
  input  logic [cluster_intc_pkg::DATA_WIDTH-1:0] bank_rdata_i [NB_TCDM_BANKS]
);

  import cluster_intc_pkg::*;

  localparam int unsigned SEL_W = $clog2(NB_TCDM_BANKS);

  tcdm_req_t           core_pld [NB_CORES];
  logic [SEL_W-1:0]    core_sel [NB_CORES];
  logic [NB_CORES-1:0] bank_core_req [NB_TCDM_BANKS];
  logic [NB_CORES-1:0] bank_core_gnt [NB_TCDM_BANKS];
  logic [CORE_W-1:0]   bank_win [NB_TCDM_BANKS];

  logic [NB_TCDM_BANKS-1:0] rvalid_q;
  logic [NB_TCDM_BANKS-1:0] rd_q;
  logic [CORE_W-1:0]        win_q [NB_TCDM_BANKS];

  //**************************************************
  // request side
  //**************************************************
  // bank index sits right above the byte offset
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      core_sel[c]       = core_tcdm_add_i[c][2 +: SEL_W];
      core_pld[c].wen   = core_tcdm_wen_i[c];
      core_pld[c].add   = core_tcdm_add_i[c][2 + SEL_W +: BANK_ADDR_WIDTH];
      core_pld[c].wdata = core_tcdm_wdata_i[c];
      core_pld[c].be    = core_tcdm_be_i[c];
    end
    for (int b = 0; b < NB_TCDM_BANKS; b++) begin
      for (int c = 0; c < NB_CORES; c++) begin
        bank_core_req[b][c] = core_tcdm_req_i[c] && (core_sel[c] == SEL_W'(b));
      end
    end
  end

  for (genvar b = 0; b < NB_TCDM_BANKS; b++) begin : gen_bank
    // a bank never stalls
    rr_arbiter #(
      .N         (NB_CORES),
      .payload_t (tcdm_req_t)
    ) i_arb (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (bank_core_req[b]),
      .data_i  (core_pld),
      .gnt_o   (bank_core_gnt[b]),
      .req_o   (bank_req_o[b]),
      .data_o  (bank_data_o[b]),
      .gnt_i   (1'b1),
      .idx_o   (bank_win[b])
    );
  end

  always_comb begin
    core_tcdm_gnt_o = '0;
    for (int b = 0; b < NB_TCDM_BANKS; b++) begin
      core_tcdm_gnt_o = core_tcdm_gnt_o | bank_core_gnt[b];
    end
  end

  //**************************************************
  // response side
  //**************************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= '0;
      rd_q     <= '0;
      for (int b = 0; b < NB_TCDM_BANKS; b++) win_q[b] <= '0;
    end else begin
      rvalid_q <= bank_req_o;
      for (int b = 0; b < NB_TCDM_BANKS; b++) begin
        rd_q[b]  <= bank_data_o[b].wen;
        win_q[b] <= bank_win[b];
      end
    end
  end

  // writes return zero data
  always_comb begin
    core_tcdm_r_valid_o = '0;
    for (int c = 0; c < NB_CORES; c++) core_tcdm_r_rdata_o[c] = '0;
    for (int b = 0; b < NB_TCDM_BANKS; b++) begin
      if (rvalid_q[b]) begin
        core_tcdm_r_valid_o[win_q[b]] = 1'b1;
        if (rd_q[b]) core_tcdm_r_rdata_o[win_q[b]] = bank_rdata_i[b];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/periph_xbar.sv
/*
 * peripheral crossbar
 * decodes the cluster peripheral window, arbitrates per slave,
 * routes responses back by id and answers stray addresses with an error
 */

`timescale 1ns/1ps
`default_nettype none

module periph_xbar #(
  parameter int unsigned NB_CORES    = 4,
  parameter int unsigned NB_SPERIPHS = 4,
  localparam int unsigned CORE_W     = (NB_CORES > 1) ? $clog2(NB_CORES) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [NB_CORES-1:0]                   core_periph_req_i,
  input  logic [cluster_intc_pkg::ADDR_WIDTH-1:0] core_periph_add_i [NB_CORES],
  input  logic [NB_CORES-1:0]                   core_periph_wen_i,
  input  logic [cluster_intc_pkg::DATA_WIDTH-1:0] core_periph_wdata_i [NB_CORES],
  input  logic [cluster_intc_pkg::BE_WIDTH-1:0]   core_periph_be_i [NB_CORES],
  output logic [NB_CORES-1:0]                   core_periph_gnt_o,
  output logic [NB_CORES-1:0]                   core_periph_r_valid_o,
  output logic [NB_CORES-1:0]                   core_periph_r_opc_o,
  output logic [cluster_intc_pkg::DATA_WIDTH-1:0] core_periph_r_rdata_o [NB_CORES],
  output logic [NB_SPERIPHS-1:0]                speriph_req_o,
  output logic [cluster_intc_pkg::ADDR_WIDTH-1:0] speriph_add_o [NB_SPERIPHS],
  output logic [NB_SPERIPHS-1:0]                speriph_wen_o,
  output logic [cluster_intc_pkg::DATA_WIDTH-1:0] speriph_wdata_o [NB_SPERIPHS],
  output logic [cluster_intc_pkg::BE_WIDTH-1:0]   speriph_be_o [NB_SPERIPHS],
  output logic [CORE_W-1:0]                     speriph_id_o [NB_SPERIPHS],
  input  logic [NB_SPERIPHS-1:0]                speriph_gnt_i,
  input  logic [NB_SPERIPHS-1:0]                speriph_r_valid_i,
  input  logic [CORE_W-1:0]                     speriph_r_id_i [NB_SPERIPHS],
  input  logic [cluster_intc_pkg::DATA_WIDTH-1:0] speriph_r_rdata_i [NB_SPERIPHS]
);

  import cluster_intc_pkg::*;

  localparam int unsigned SLV_W = (NB_SPERIPHS > 1) ? $clog2(NB_SPERIPHS) : 1;
  localparam logic [ADDR_WIDTH-1:0] WIN_END =
    CLUSTER_PERIPH_BASE + (ADDR_WIDTH'(NB_SPERIPHS) << PE_ROUTING_LSB);

  periph_req_t         core_pld [NB_CORES];
  logic [NB_CORES-1:0] in_win;
  logic [SLV_W-1:0]    core_sel [NB_CORES];
  logic [NB_CORES-1:0] slv_core_req [NB_SPERIPHS];
  logic [NB_CORES-1:0] slv_core_gnt [NB_SPERIPHS];
  logic [NB_CORES-1:0] err_q;

  // window and slot decode per core
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      in_win[c] = (core_periph_add_i[c] >= CLUSTER_PERIPH_BASE) &&
                  (core_periph_add_i[c] < WIN_END);
      core_sel[c]       = core_periph_add_i[c][PE_ROUTING_LSB +: SLV_W];
      core_pld[c].wen   = core_periph_wen_i[c];
      core_pld[c].add   = core_periph_add_i[c];
      core_pld[c].wdata = core_periph_wdata_i[c];
      core_pld[c].be    = core_periph_be_i[c];
    end
    for (int s = 0; s < NB_SPERIPHS; s++) begin
      for (int c = 0; c < NB_CORES; c++) begin
        slv_core_req[s][c] = core_periph_req_i[c] && in_win[c] &&
                             (core_sel[c] == SLV_W'(s));
      end
    end
  end

  for (genvar s = 0; s < NB_SPERIPHS; s++) begin : gen_slv
    periph_req_t slv_pld;

    rr_arbiter #(
      .N         (NB_CORES),
      .payload_t (periph_req_t)
    ) i_arb (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (slv_core_req[s]),
      .data_i  (core_pld),
      .gnt_o   (slv_core_gnt[s]),
      .req_o   (speriph_req_o[s]),
      .data_o  (slv_pld),
      .gnt_i   (speriph_gnt_i[s]),
      .idx_o   (speriph_id_o[s])
    );

    assign speriph_add_o[s]   = slv_pld.add;
    assign speriph_wen_o[s]   = slv_pld.wen;
    assign speriph_wdata_o[s] = slv_pld.wdata;
    assign speriph_be_o[s]    = slv_pld.be;
  end

  // stray addresses are accepted at once
  always_comb begin
    core_periph_gnt_o = core_periph_req_i & ~in_win;
    for (int s = 0; s < NB_SPERIPHS; s++) begin
      core_periph_gnt_o = core_periph_gnt_o | slv_core_gnt[s];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_q <= '0;
    end else begin
      err_q <= core_periph_req_i & ~in_win;
    end
  end

  // responses go back by id, error data stays zero
  always_comb begin
    core_periph_r_valid_o = err_q;
    core_periph_r_opc_o   = err_q;
    for (int c = 0; c < NB_CORES; c++) core_periph_r_rdata_o[c] = '0;
    for (int s = 0; s < NB_SPERIPHS; s++) begin
      if (speriph_r_valid_i[s]) begin
        core_periph_r_valid_o[speriph_r_id_i[s]] = 1'b1;
        core_periph_r_rdata_o[speriph_r_id_i[s]] = speriph_r_rdata_i[s];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/cluster_interconnect_wrap.sv
/*
 * cluster interconnect top level
 * core ports into the TCDM interconnect and its SRAM banks,
 * and into the peripheral crossbar toward the slaves
 */

`timescale 1ns/1ps
`default_nettype none

module cluster_interconnect_wrap #(
  parameter int unsigned NB_CORES      = 4,
  parameter int unsigned NB_TCDM_BANKS = 8,
  parameter int unsigned NB_SPERIPHS   = 4,
  localparam int unsigned CORE_W       = (NB_CORES > 1) ? $clog2(NB_CORES) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [NB_CORES-1:0]                   core_tcdm_req_i,
  input  logic [cluster_intc_pkg::ADDR_WIDTH-1:0] core_tcdm_add_i [NB_CORES],
  input  logic [NB_CORES-1:0]                   core_tcdm_wen_i,
  input  logic [cluster_intc_pkg::DATA_WIDTH-1:0] core_tcdm_wdata_i [NB_CORES],
  input  logic [cluster_intc_pkg::BE_WIDTH-1:0]   core_tcdm_be_i [NB_CORES],
  output logic [NB_CORES-1:0]                   core_tcdm_gnt_o,
  output logic [NB_CORES-1:0]                   core_tcdm_r_valid_o,
  output logic [cluster_intc_pkg::DATA_WIDTH-1:0] core_tcdm_r_rdata_o [NB_CORES],
  input  logic [NB_CORES-1:0]                   core_periph_req_i,
  input  logic [cluster_intc_pkg::ADDR_WIDTH-1:0] core_periph_add_i [NB_CORES],
  input  logic [NB_CORES-1:0]                   core_periph_wen_i,
  input  logic [cluster_intc_pkg::DATA_WIDTH-1:0] core_periph_wdata_i [NB_CORES],
  input  logic [cluster_intc_pkg::BE_WIDTH-1:0]   core_periph_be_i [NB_CORES],
  output logic [NB_CORES-1:0]                   core_periph_gnt_o,
  output logic [NB_CORES-1:0]                   core_periph_r_valid_o,
  output logic [NB_CORES-1:0]                   core_periph_r_opc_o,
  output logic [cluster_intc_pkg::DATA_WIDTH-1:0] core_periph_r_rdata_o [NB_CORES],
  output logic [NB_SPERIPHS-1:0]                speriph_req_o,
  output logic [cluster_intc_pkg::ADDR_WIDTH-1:0] speriph_add_o [NB_SPERIPHS],
  output logic [NB_SPERIPHS-1:0]                speriph_wen_o,
  output logic [cluster_intc_pkg::DATA_WIDTH-1:0] speriph_wdata_o [NB_SPERIPHS],
  output logic [cluster_intc_pkg::BE_WIDTH-1:0]   speriph_be_o [NB_SPERIPHS],
  output logic [CORE_W-1:0]                     speriph_id_o [NB_SPERIPHS],
  input  logic [NB_SPERIPHS-1:0]                speriph_gnt_i,
  input  logic [NB_SPERIPHS-1:0]                speriph_r_valid_i,
  input  logic [CORE_W-1:0]                     speriph_r_id_i [NB_SPERIPHS],
  input  logic [cluster_intc_pkg::DATA_WIDTH-1:0] speriph_r_rdata_i [NB_SPERIPHS]
);

  import cluster_intc_pkg::*;

  logic [NB_TCDM_BANKS-1:0] bank_req;
  tcdm_req_t                bank_data [NB_TCDM_BANKS];
  logic [DATA_WIDTH-1:0]    bank_rdata [NB_TCDM_BANKS];

  //**************************************************
  // TCDM path
  //**************************************************
  tcdm_log_intc #(
    .NB_CORES      (NB_CORES),
    .NB_TCDM_BANKS (NB_TCDM_BANKS)
  ) i_tcdm_intc (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .core_tcdm_req_i     (core_tcdm_req_i),
    .core_tcdm_add_i     (core_tcdm_add_i),
    .core_tcdm_wen_i     (core_tcdm_wen_i),
    .core_tcdm_wdata_i   (core_tcdm_wdata_i),
    .core_tcdm_be_i      (core_tcdm_be_i),
    .core_tcdm_gnt_o     (core_tcdm_gnt_o),
    .core_tcdm_r_valid_o (core_tcdm_r_valid_o),
    .core_tcdm_r_rdata_o (core_tcdm_r_rdata_o),
    .bank_req_o          (bank_req),
    .bank_data_o         (bank_data),
    .bank_rdata_i        (bank_rdata)
  );

  for (genvar b = 0; b < NB_TCDM_BANKS; b++) begin : gen_sram
    tcdm_bank_sram i_bank (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (bank_req[b]),
      .wen_i   (bank_data[b].wen),
      .add_i   (bank_data[b].add),
      .wdata_i (bank_data[b].wdata),
      .be_i    (bank_data[b].be),
      .rdata_o (bank_rdata[b])
    );
  end

  //**************************************************
  // peripheral path
  //**************************************************
  periph_xbar #(
    .NB_CORES    (NB_CORES),
    .NB_SPERIPHS (NB_SPERIPHS)
  ) i_periph_xbar (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .core_periph_req_i     (core_periph_req_i),
    .core_periph_add_i     (core_periph_add_i),
    .core_periph_wen_i     (core_periph_wen_i),
    .core_periph_wdata_i   (core_periph_wdata_i),
    .core_periph_be_i      (core_periph_be_i),
    .core_periph_gnt_o     (core_periph_gnt_o),
    .core_periph_r_valid_o (core_periph_r_valid_o),
    .core_periph_r_opc_o   (core_periph_r_opc_o),
    .core_periph_r_rdata_o (core_periph_r_rdata_o),
    .speriph_req_o         (speriph_req_o),
    .speriph_add_o         (speriph_add_o),
    .speriph_wen_o         (speriph_wen_o),
    .speriph_wdata_o       (speriph_wdata_o),
    .speriph_be_o          (speriph_be_o),
    .speriph_id_o          (speriph_id_o),
    .speriph_gnt_i         (speriph_gnt_i),
    .speriph_r_valid_i     (speriph_r_valid_i),
    .speriph_r_id_i        (speriph_r_id_i),
    .speriph_r_rdata_i     (speriph_r_rdata_i)
  );

endmodule

`default_nettype wire

// File: tests/cluster_interconnect_assert.sv
/*
 * TCDM interconnect checks
 * grants only for requests, responses one cycle after the grant,
 * exactly one granted core per active bank
 */

`timescale 1ns/1ps
`default_nettype none

module cluster_interconnect_assert #(
  parameter int unsigned NB_CORES      = 4,
  parameter int unsigned NB_TCDM_BANKS = 8
) (
  input logic                     clk_i,
  input logic                     reset_i,
  input logic [NB_CORES-1:0]      core_tcdm_req_i,
  input logic [NB_CORES-1:0]      core_tcdm_gnt_o,
  input logic [NB_CORES-1:0]      core_tcdm_r_valid_o,
  input logic [NB_TCDM_BANKS-1:0] bank_req_o
);

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    (core_tcdm_gnt_o & ~core_tcdm_req_i) == '0)
    else $error("grant without request");

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    core_tcdm_r_valid_o == $past(core_tcdm_gnt_o))
    else $error("r_valid does not follow the grant by one cycle");

  // each core targets one bank, so granted cores must match busy banks
  one_gnt_per_bank: assert property (@(posedge clk_i) disable iff (reset_i)
    $countones(core_tcdm_gnt_o) == $countones(bank_req_o))
    else $error("bank grants and core grants disagree");

endmodule

bind tcdm_log_intc cluster_interconnect_assert #(
  .NB_CORES      (NB_CORES),
  .NB_TCDM_BANKS (NB_TCDM_BANKS)
) i_intc_assert (
  .clk_i               (clk_i),
  .reset_i             (reset_i),
  .core_tcdm_req_i     (core_tcdm_req_i),
  .core_tcdm_gnt_o     (core_tcdm_gnt_o),
  .core_tcdm_r_valid_o (core_tcdm_r_valid_o),
  .bank_req_o          (bank_req_o)
);

`default_nettype wire

// File: tests/tb_cluster_interconnect.sv
/*
 * cluster interconnect testbench
 * drives the core TCDM and peripheral ports through directed tests,
 * models the peripheral slaves and keeps a reference copy of the TCDM
 */

`timescale 1ns/1ps
`default_nettype none

module tb_cluster_interconnect;

  import cluster_intc_pkg::*;

  localparam int unsigned NB_CORES      = 4;
  localparam int unsigned NB_TCDM_BANKS = 8;
  localparam int unsigned NB_SPERIPHS   = 4;
  localparam int unsigned CORE_W        = (NB_CORES > 1) ? $clog2(NB_CORES) : 1;
  localparam int unsigned WORD_IDX_W    = $clog2(NB_TCDM_BANKS) + BANK_ADDR_WIDTH;
  localparam int unsigned CLK_PERIOD    = 20;
  localparam int unsigned NB_TESTS      = 5;
  localparam logic [DATA_WIDTH-1:0] RESP_MASK = 32'h5a5a_5a5a;
  localparam logic [ADDR_WIDTH-1:0] WIN_END   =
    CLUSTER_PERIPH_BASE + ADDR_WIDTH'(NB_SPERIPHS << PE_ROUTING_LSB);

  logic                   clk_i;
  logic                   reset_i;
  logic [NB_CORES-1:0]    core_tcdm_req_i;
  logic [ADDR_WIDTH-1:0]  core_tcdm_add_i [NB_CORES];
  logic [NB_CORES-1:0]    core_tcdm_wen_i;
  logic [DATA_WIDTH-1:0]  core_tcdm_wdata_i [NB_CORES];
  logic [BE_WIDTH-1:0]    core_tcdm_be_i [NB_CORES];
  logic [NB_CORES-1:0]    core_tcdm_gnt_o;
  logic [NB_CORES-1:0]    core_tcdm_r_valid_o;
  logic [DATA_WIDTH-1:0]  core_tcdm_r_rdata_o [NB_CORES];
  logic [NB_CORES-1:0]    core_periph_req_i;
  logic [ADDR_WIDTH-1:0]  core_periph_add_i [NB_CORES];
  logic [NB_CORES-1:0]    core_periph_wen_i;
  logic [DATA_WIDTH-1:0]  core_periph_wdata_i [NB_CORES];
  logic [BE_WIDTH-1:0]    core_periph_be_i [NB_CORES];
  logic [NB_CORES-1:0]    core_periph_gnt_o;
  logic [NB_CORES-1:0]    core_periph_r_valid_o;
  logic [NB_CORES-1:0]    core_periph_r_opc_o;
  logic [DATA_WIDTH-1:0]  core_periph_r_rdata_o [NB_CORES];
  logic [NB_SPERIPHS-1:0] speriph_req_o;
  logic [ADDR_WIDTH-1:0]  speriph_add_o [NB_SPERIPHS];
  logic [NB_SPERIPHS-1:0] speriph_wen_o;
  logic [DATA_WIDTH-1:0]  speriph_wdata_o [NB_SPERIPHS];
  logic [BE_WIDTH-1:0]    speriph_be_o [NB_SPERIPHS];
  logic [CORE_W-1:0]      speriph_id_o [NB_SPERIPHS];
  logic [NB_SPERIPHS-1:0] speriph_gnt_i;
  wire  [NB_SPERIPHS-1:0] speriph_r_valid_i;
  wire  [CORE_W-1:0]      speriph_r_id_i [NB_SPERIPHS];
  wire  [DATA_WIDTH-1:0]  speriph_r_rdata_i [NB_SPERIPHS];

  // reference copy of the whole TCDM, indexed by word
  logic [DATA_WIDTH-1:0] ref_mem [2**WORD_IDX_W];
  logic run_passed  = 1'b0;
  logic run_aborted = 1'b0;

  cluster_interconnect_wrap #(
    .NB_CORES      (NB_CORES),
    .NB_TCDM_BANKS (NB_TCDM_BANKS),
    .NB_SPERIPHS   (NB_SPERIPHS)
  ) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // slaves accept everything
  assign speriph_gnt_i = '1;

  //**************************************************
  // peripheral slave models
  //**************************************************
  for (genvar s = 0; s < NB_SPERIPHS; s++) begin : gen_slave
    logic                  rv;
    logic [CORE_W-1:0]     rid;
    logic [DATA_WIDTH-1:0] rdat;

    assign speriph_r_valid_i[s] = rv;
    assign speriph_r_id_i[s]    = rid;
    assign speriph_r_rdata_i[s] = rdat;

    initial begin : model
      int unsigned           lat;
      logic [CORE_W-1:0]     cap_id;
      logic [ADDR_WIDTH-1:0] cap_add;
      rv   = 1'b0;
      rid  = '0;
      rdat = '0;
      forever begin
        @(negedge clk_i);
        if (speriph_req_o[s] && !reset_i) begin
          cap_id  = speriph_id_o[s];
          cap_add = speriph_add_o[s];
          lat     = $urandom_range(3, 1);
          repeat (lat) @(posedge clk_i);
          #2;
          rv   = 1'b1;
          rid  = cap_id;
          rdat = cap_add ^ RESP_MASK;
          @(posedge clk_i);
          #2;
          rv   = 1'b0;
          rdat = '0;
        end
      end
    end
  end

  //**************************************************
  // helpers and compare tasks
  //**************************************************
  task automatic abort_run(input string why);
    run_aborted = 1'b1;
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_opc(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_idx(input string name, input logic [CORE_W-1:0] got,
                           input logic [CORE_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_be(input string name, input logic [BE_WIDTH-1:0] got,
                          input logic [BE_WIDTH-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  function automatic logic [DATA_WIDTH-1:0] ref_word(input logic [ADDR_WIDTH-1:0] addr);
    return ref_mem[addr[2 +: WORD_IDX_W]];
  endfunction

  // one word in bank 3 per core
  function automatic logic [ADDR_WIDTH-1:0] conflict_addr(input int c);
    return ADDR_WIDTH'(4 * (3 + NB_TCDM_BANKS * (16 + c)));
  endfunction

  task automatic check_tcdm_resp(input int c, input logic [DATA_WIDTH-1:0] exp);
    check_opc($sformatf("core_tcdm_r_valid_o[%0d]", c), core_tcdm_r_valid_o[c], 1'b1);
    check_data($sformatf("core_tcdm_r_rdata_o[%0d]", c), core_tcdm_r_rdata_o[c], exp);
  endtask

  // single uncontended transfer, updates the reference on writes
  task automatic tcdm_access(input int c, input logic [ADDR_WIDTH-1:0] addr,
                             input logic wen, input logic [DATA_WIDTH-1:0] wdata,
                             input logic [BE_WIDTH-1:0] be);
    logic [WORD_IDX_W-1:0] widx;
    logic [DATA_WIDTH-1:0] exp;
    widx = addr[2 +: WORD_IDX_W];
    core_tcdm_req_i[c]   = 1'b1;
    core_tcdm_add_i[c]   = addr;
    core_tcdm_wen_i[c]   = wen;
    core_tcdm_wdata_i[c] = wdata;
    core_tcdm_be_i[c]    = be;
    @(negedge clk_i);
    check_opc($sformatf("core_tcdm_gnt_o[%0d]", c), core_tcdm_gnt_o[c], 1'b1);
    if (!wen) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (be[b]) ref_mem[widx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    exp = wen ? ref_mem[widx] : '0;
    next_cycle();
    core_tcdm_req_i[c] = 1'b0;
    @(negedge clk_i);
    check_tcdm_resp(c, exp);
    next_cycle();
  endtask

  //**************************************************
  // directed tests
  //**************************************************
  task automatic write_read_test();
    for (int w = 0; w < 2 * NB_TCDM_BANKS; w++)
      tcdm_access(0, ADDR_WIDTH'(4 * w), 1'b0, $urandom(), '1);
    for (int w = 0; w < 2 * NB_TCDM_BANKS; w++)
      tcdm_access(0, ADDR_WIDTH'(4 * w), 1'b1, '0, '1);
  endtask

  task automatic byte_enable_test();
    logic [ADDR_WIDTH-1:0] addr;
    addr = 32'h0000_0114;
    tcdm_access(1, addr, 1'b0, 32'h1122_3344, '1);
    tcdm_access(1, addr, 1'b0, $urandom(), 4'b0101);
    tcdm_access(1, addr, 1'b0, $urandom(), 4'b1000);
    tcdm_access(1, addr, 1'b1, '0, '1);
  endtask

  task automatic conflict_test();
    logic [NB_CORES-1:0] pending;
    logic [NB_CORES-1:0] got;
    int                  last;
    for (int c = 0; c < NB_CORES; c++)
      tcdm_access(0, conflict_addr(c), 1'b0, $urandom(), '1);
    for (int c = 0; c < NB_CORES; c++) begin
      core_tcdm_add_i[c] = conflict_addr(c);
      core_tcdm_wen_i[c] = 1'b1;
    end
    core_tcdm_req_i = '1;
    pending = '1;
    last    = -1;
    // one winner per cycle, each response one cycle behind its grant
    // core 0 used bank 3 last, so priority starts at core 1
    for (int k = 0; k < NB_CORES; k++) begin
      @(negedge clk_i);
      if (last >= 0) check_tcdm_resp(last, ref_word(conflict_addr(last)));
      got = core_tcdm_gnt_o;
      if ($countones(got) != 1 || (got & ~pending) != '0)
        abort_run($sformatf("bank conflict grant %b does not pick one waiting core", got));
      for (int c = 0; c < NB_CORES; c++) begin
        if (got[c]) last = c;
      end
      check_idx("core_tcdm_gnt_o winner", CORE_W'(last), CORE_W'((1 + k) % NB_CORES));
      pending = pending & ~got;
      next_cycle();
      core_tcdm_req_i = core_tcdm_req_i & ~got;
    end
    @(negedge clk_i);
    check_tcdm_resp(last, ref_word(conflict_addr(last)));
    next_cycle();
    // distinct banks go through together
    for (int c = 0; c < NB_CORES; c++) core_tcdm_add_i[c] = ADDR_WIDTH'(4 * c);
    core_tcdm_req_i = '1;
    @(negedge clk_i);
    for (int c = 0; c < NB_CORES; c++)
      check_opc($sformatf("core_tcdm_gnt_o[%0d]", c), core_tcdm_gnt_o[c], 1'b1);
    next_cycle();
    core_tcdm_req_i = '0;
    @(negedge clk_i);
    for (int c = 0; c < NB_CORES; c++) check_tcdm_resp(c, ref_word(ADDR_WIDTH'(4 * c)));
    next_cycle();
  endtask

  task automatic periph_access(input int c, input int s, input logic [ADDR_WIDTH-1:0] addr);
    int                    waited;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0]   be;
    logic                  wen;
    wdata = $urandom();
    be    = BE_WIDTH'(c + s + 1);
    wen   = (s % 2 == 1);
    core_periph_req_i[c]   = 1'b1;
    core_periph_add_i[c]   = addr;
    core_periph_wen_i[c]   = wen;
    core_periph_wdata_i[c] = wdata;
    core_periph_be_i[c]    = be;
    @(negedge clk_i);
    check_opc($sformatf("core_periph_gnt_o[%0d]", c), core_periph_gnt_o[c], 1'b1);
    for (int t = 0; t < NB_SPERIPHS; t++)
      check_opc($sformatf("speriph_req_o[%0d]", t), speriph_req_o[t], t == s);
    check_idx($sformatf("speriph_id_o[%0d]", s), speriph_id_o[s], CORE_W'(c));
    check_data($sformatf("speriph_add_o[%0d]", s), speriph_add_o[s], addr);
    check_opc($sformatf("speriph_wen_o[%0d]", s), speriph_wen_o[s], wen);
    check_data($sformatf("speriph_wdata_o[%0d]", s), speriph_wdata_o[s], wdata);
    check_be($sformatf("speriph_be_o[%0d]", s), speriph_be_o[s], be);
    next_cycle();
    core_periph_req_i[c] = 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (!core_periph_r_valid_o[c]) begin
      waited++;
      if (waited > 4) abort_run($sformatf("no peripheral response reached core %0d", c));
      @(negedge clk_i);
    end
    check_data($sformatf("core_periph_r_rdata_o[%0d]", c), core_periph_r_rdata_o[c],
               addr ^ RESP_MASK);
    check_opc($sformatf("core_periph_r_opc_o[%0d]", c), core_periph_r_opc_o[c], 1'b0);
    next_cycle();
  endtask

  task automatic periph_route_test();
    for (int c = 0; c < NB_CORES; c++) begin
      for (int s = 0; s < NB_SPERIPHS; s++)
        periph_access(c, s, CLUSTER_PERIPH_BASE + ADDR_WIDTH'((s << PE_ROUTING_LSB) + 4 * c));
    end
  endtask

  task automatic stray_addr_test();
    logic [ADDR_WIDTH-1:0] addr;
    for (int c = 0; c < NB_CORES; c++) begin
      // just below and just above the window
      addr = (c % 2 == 0) ? CLUSTER_PERIPH_BASE - ADDR_WIDTH'(4 * (c + 1))
                          : WIN_END + ADDR_WIDTH'(4 * c);
      core_periph_req_i[c] = 1'b1;
      core_periph_add_i[c] = addr;
      @(negedge clk_i);
      check_opc($sformatf("core_periph_gnt_o[%0d]", c), core_periph_gnt_o[c], 1'b1);
      for (int s = 0; s < NB_SPERIPHS; s++)
        check_opc($sformatf("speriph_req_o[%0d]", s), speriph_req_o[s], 1'b0);
      next_cycle();
      core_periph_req_i[c] = 1'b0;
      @(negedge clk_i);
      check_opc($sformatf("core_periph_r_valid_o[%0d]", c), core_periph_r_valid_o[c], 1'b1);
      check_opc($sformatf("core_periph_r_opc_o[%0d]", c), core_periph_r_opc_o[c], 1'b1);
      check_data($sformatf("core_periph_r_rdata_o[%0d]", c), core_periph_r_rdata_o[c], '0);
      next_cycle();
    end
  endtask

  //**************************************************
  // main sequence and watchdog
  //**************************************************
  initial begin
    void'($urandom(32'hc7b3));
    reset_i           = 1'b1;
    core_tcdm_req_i   = '0;
    core_tcdm_wen_i   = '0;
    core_periph_req_i = '0;
    core_periph_wen_i = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      core_tcdm_add_i[c]     = '0;
      core_tcdm_wdata_i[c]   = '0;
      core_tcdm_be_i[c]      = '0;
      core_periph_add_i[c]   = '0;
      core_periph_wdata_i[c] = '0;
      core_periph_be_i[c]    = '1;
    end
    repeat (2) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    write_read_test();
    byte_enable_test();
    conflict_test();
    periph_route_test();
    stray_addr_test();
    run_passed = 1'b1;
    $display("Simulation PASSED");
    $finish;
  end

  initial begin : watchdog
    #(NB_TESTS * 200 * CLK_PERIOD);
    abort_run("watchdog expired before the tests finished");
  end

  final begin
    if (!run_passed && !run_aborted) $display("Simulation FAILED");
  end

endmodule

`default_nettype wire

// File: cluster_interconnect_wrap.f
rtl/cluster_intc_pkg.sv
rtl/rr_arbiter.sv
rtl/tcdm_bank_sram.sv
rtl/tcdm_log_intc.sv
rtl/periph_xbar.sv
rtl/cluster_interconnect_wrap.sv
tests/cluster_interconnect_assert.sv
tests/tb_cluster_interconnect.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cluster interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cluster_interconnect -Mdir obj_dir -o simv \
    -f cluster_interconnect_wrap.f; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
  exit 0
fi
exit 1
